/* all.f */
+incdir+common
common/core_pkg.sv
design/decoder.sv
design/imm_gen.sv
design/alu.sv
design/branch_unit.sv
design/reg_file.sv
design/pc_unit.sv
design/rv_core_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

/* common/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and address width
`define CORE_XLEN 32

// architectural register count
`define CORE_NREGS 32

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

`endif

/* common/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_PC4
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_kind_e;

    typedef struct packed {
        logic      a_sel_pc;   // operand a from pc instead of rs1
        logic      b_sel_imm;  // operand b from immediate instead of rs2
        alu_op_e   alu_op;
        branch_e   branch;
        wb_sel_e   wb_sel;
        logic      reg_we;
        logic      jump;       // jal or jalr
        logic      jalr;
        imm_kind_e imm_kind;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           inst;
        logic [4:0]            rd;
        logic                  we;       // architectural write, never x0
        logic [`CORE_XLEN-1:0] w_data;
        logic                  illegal;
        logic                  is_call;
        logic                  is_ret;
        logic                  is_tail;
    } commit_t;

endpackage

/* design/alu.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module alu (
    input  core_pkg::ctrl_t       ctrl,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    input  logic [`CORE_XLEN-1:0] imm,
    output logic [`CORE_XLEN-1:0] alu_out
);

    localparam int SHW = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [SHW-1:0]        shamt;

    assign op_a  = ctrl.a_sel_pc ? pc : rs1_data;
    assign op_b  = ctrl.b_sel_imm ? imm : rs2_data;
    assign shamt = op_b[SHW-1:0];  // low bits only

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::ALU_ADD:    alu_out = op_a + op_b;
            core_pkg::ALU_SUB:    alu_out = op_a - op_b;
            core_pkg::ALU_SLL:    alu_out = op_a << shamt;
            core_pkg::ALU_SLT:    alu_out = `CORE_XLEN'($signed(op_a) < $signed(op_b));
            core_pkg::ALU_SLTU:   alu_out = `CORE_XLEN'(op_a < op_b);
            core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            core_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            core_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:     alu_out = op_a | op_b;
            core_pkg::ALU_AND:    alu_out = op_a & op_b;
            core_pkg::ALU_PASS_B: alu_out = op_b;  // lui
            default:              alu_out = '0;
        endcase
    end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module branch_unit (
    input  core_pkg::branch_e     branch,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    output logic                  branch_taken
);

    logic eq;
    logic lt;   // signed
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        case (branch)
            core_pkg::BR_EQ:  branch_taken = eq;
            core_pkg::BR_NE:  branch_taken = !eq;
            core_pkg::BR_LT:  branch_taken = lt;
            core_pkg::BR_GE:  branch_taken = !lt;
            core_pkg::BR_LTU: branch_taken = ltu;
            core_pkg::BR_GEU: branch_taken = !ltu;
            default:          branch_taken = 1'b0;  // not a branch
        endcase
    end

endmodule

/* design/decoder.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module decoder (
    input  logic [31:0]           inst,
    input  logic [`CORE_XLEN-1:0] imm,
    output core_pkg::ctrl_t       ctrl,
    output logic                  is_call,
    output logic                  is_ret,
    output logic                  is_tail
);

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [4:0]        rd;
    logic              f7_alt;

    assign opcode = core_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign f7_alt = (funct7 == 7'h20);  // sub / sra encoding

    // funct3 to alu function, alt picks sub and sra
    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl.a_sel_pc  = 1'b0;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = core_pkg::ALU_ADD;
        ctrl.branch    = core_pkg::BR_NONE;
        ctrl.wb_sel    = core_pkg::WB_ALU;
        ctrl.reg_we    = 1'b1;
        ctrl.jump      = 1'b0;
        ctrl.jalr      = 1'b0;
        ctrl.imm_kind  = core_pkg::IMM_I;
        ctrl.illegal   = 1'b0;
        case (opcode)
            core_pkg::OP_LUI: begin
                ctrl.alu_op   = core_pkg::ALU_PASS_B;
                ctrl.imm_kind = core_pkg::IMM_U;
            end
            core_pkg::OP_AUIPC: begin
                ctrl.a_sel_pc = 1'b1;
                ctrl.imm_kind = core_pkg::IMM_U;
            end
            core_pkg::OP_JAL: begin
                ctrl.a_sel_pc = 1'b1;  // target = pc + imm
                ctrl.imm_kind = core_pkg::IMM_J;
                ctrl.wb_sel   = core_pkg::WB_PC4;
                ctrl.jump     = 1'b1;
            end
            core_pkg::OP_JALR: begin
                ctrl.wb_sel  = core_pkg::WB_PC4;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.illegal = (funct3 != 3'b000);
            end
            core_pkg::OP_BRANCH: begin
                ctrl.a_sel_pc = 1'b1;
                ctrl.imm_kind = core_pkg::IMM_B;
                ctrl.wb_sel   = core_pkg::WB_NONE;
                ctrl.reg_we   = 1'b0;
                case (funct3)
                    3'b000:  ctrl.branch = core_pkg::BR_EQ;
                    3'b001:  ctrl.branch = core_pkg::BR_NE;
                    3'b100:  ctrl.branch = core_pkg::BR_LT;
                    3'b101:  ctrl.branch = core_pkg::BR_GE;
                    3'b110:  ctrl.branch = core_pkg::BR_LTU;
                    3'b111:  ctrl.branch = core_pkg::BR_GEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            core_pkg::OP_IMM: begin
                ctrl.alu_op  = alu_sel(funct3, funct3 == 3'b101 && f7_alt);
                ctrl.illegal = (funct3 == 3'b001 && funct7 != 7'h00) ||
                               (funct3 == 3'b101 && funct7 != 7'h00 && !f7_alt);
            end
            core_pkg::OP_REG: begin
                ctrl.b_sel_imm = 1'b0;
                ctrl.alu_op    = alu_sel(funct3, f7_alt);
                ctrl.illegal   = !(funct7 == 7'h00 ||
                                   (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            core_pkg::OP_LOAD, core_pkg::OP_STORE: ctrl.illegal = 1'b1;  // no memory port
            default: ctrl.illegal = 1'b1;
        endcase
        // an illegal word only moves the pc on
        if (ctrl.illegal) begin
            ctrl.branch = core_pkg::BR_NONE;
            ctrl.wb_sel = core_pkg::WB_NONE;
            ctrl.reg_we = 1'b0;
            ctrl.jump   = 1'b0;
            ctrl.jalr   = 1'b0;
        end
    end

    // function trace flags
    assign is_call = ctrl.jump && (rd == 5'd1);
    assign is_ret  = ctrl.jalr && (inst == 32'h0000_8067);  // jalr x0, 0(x1)
    assign is_tail = ctrl.jalr && !is_ret && (rd == 5'd0) && (imm == '0);

endmodule

/* design/imm_gen.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module imm_gen (
    input  logic [31:0]           inst,
    input  core_pkg::imm_kind_e   imm_kind,
    output logic [`CORE_XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_kind)
            core_pkg::IMM_I: imm = {{(`CORE_XLEN-12){sign}}, inst[31:20]};
            core_pkg::IMM_S: imm = {{(`CORE_XLEN-12){sign}}, inst[31:25], inst[11:7]};
            core_pkg::IMM_B: imm = {{(`CORE_XLEN-13){sign}}, inst[31], inst[7],
                                    inst[30:25], inst[11:8], 1'b0};
            core_pkg::IMM_U: imm = {{(`CORE_XLEN-31){sign}}, inst[30:12], 12'b0};  // upper 20
            core_pkg::IMM_J: imm = {{(`CORE_XLEN-21){sign}}, inst[31], inst[19:12],
                                    inst[20], inst[30:21], 1'b0};
            default:         imm = '0;
        endcase
    end

endmodule

/* design/pc_unit.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::ctrl_t       ctrl,
    input  logic                  branch_taken,
    input  logic [`CORE_XLEN-1:0] alu_out,
    output logic [`CORE_XLEN-1:0] pc,
    output logic [`CORE_XLEN-1:0] pc_plus4
);

    logic [`CORE_XLEN-1:0] target;
    logic                  take_target;

    assign pc_plus4 = pc + `CORE_XLEN'd4;

    // jalr drops bit 0 of rs1 + imm
    assign target = ctrl.jalr ? {alu_out[`CORE_XLEN-1:1], 1'b0} : alu_out;

    assign take_target = ctrl.jump || branch_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else if (take_target) begin
            pc <= target;
        end else begin
            pc <= pc_plus4;  // sequential and illegal
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           inst,
    input  core_pkg::ctrl_t       ctrl,
    input  logic [`CORE_XLEN-1:0] alu_out,
    input  logic [`CORE_XLEN-1:0] pc_plus4,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] w_data
);

    localparam int AW = $clog2(`CORE_NREGS);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    logic [AW-1:0]         rs1_addr;
    logic [AW-1:0]         rs2_addr;
    logic [AW-1:0]         rd_addr;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    // x0 reads zero whatever the array holds
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_comb begin
        case (ctrl.wb_sel)
            core_pkg::WB_ALU: w_data = alu_out;
            core_pkg::WB_PC4: w_data = pc_plus4;  // link address
            default:          w_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we && rd_addr != '0) begin
            regs[rd_addr] <= w_data;
        end
    end

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           inst,
    output logic [`CORE_XLEN-1:0] pc,
    output core_pkg::commit_t     commit
);

    core_pkg::ctrl_t       ctrl;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic [`CORE_XLEN-1:0] alu_out;
    logic [`CORE_XLEN-1:0] pc_plus4;
    logic [`CORE_XLEN-1:0] w_data;
    logic                  branch_taken;
    logic                  is_call;
    logic                  is_ret;
    logic                  is_tail;

    decoder decoder_i (
        .inst    (inst),
        .imm     (imm),
        .ctrl    (ctrl),
        .is_call (is_call),
        .is_ret  (is_ret),
        .is_tail (is_tail)
    );

    imm_gen imm_gen_i (
        .inst     (inst),
        .imm_kind (ctrl.imm_kind),
        .imm      (imm)
    );

    alu alu_i (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .alu_out  (alu_out)
    );

    branch_unit branch_unit_i (
        .branch       (ctrl.branch),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .branch_taken (branch_taken)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .inst     (inst),
        .ctrl     (ctrl),
        .alu_out  (alu_out),
        .pc_plus4 (pc_plus4),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .w_data   (w_data)
    );

    pc_unit pc_unit_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .branch_taken (branch_taken),
        .alu_out      (alu_out),
        .pc           (pc),
        .pc_plus4     (pc_plus4)
    );

    // commit record for the instruction executing this cycle
    always_comb begin
        commit.valid   = !rst;
        commit.pc      = pc;
        commit.inst    = inst;
        commit.rd      = inst[11:7];
        commit.we      = ctrl.reg_we && (inst[11:7] != 5'd0);  // x0 writes are dropped
        commit.w_data  = w_data;
        commit.illegal = ctrl.illegal;
        commit.is_call = is_call;
        commit.is_ret  = is_ret;
        commit.is_tail = is_tail;
    end

endmodule

/* test/core_stimulus.txt */
# program:  P <byte address hex> <instruction word hex>
# expected: E <pc hex> <rd> <we> <w_data hex> <illegal> <call> <ret> <tail>, grouped under T <test>
P 00000000 00500093  addi  x1, x0, 5
P 00000004 FFD00113  addi  x2, x0, -3
P 00000008 0FF14193  xori  x3, x2, 0xff
P 0000000C 0A00E213  ori   x4, x1, 0xa0
P 00000010 7F01F293  andi  x5, x3, 0x7f0
P 00000014 00112313  slti  x6, x2, 1
P 00000018 00113393  sltiu x7, x2, 1
P 0000001C 00409413  slli  x8, x1, 4
P 00000020 01C15493  srli  x9, x2, 28
P 00000024 40115513  srai  x10, x2, 1
P 00000028 00708013  addi  x0, x1, 7
P 0000002C 002085B3  add   x11, x1, x2
P 00000030 40208633  sub   x12, x1, x2
P 00000034 001096B3  sll   x13, x1, x1
P 00000038 00112733  slt   x14, x2, x1
P 0000003C 001137B3  sltu  x15, x2, x1
P 00000040 0041C833  xor   x16, x3, x4
P 00000044 001158B3  srl   x17, x2, x1
P 00000048 40115933  sra   x18, x2, x1
P 0000004C 0080E9B3  or    x19, x1, x8
P 00000050 00417A33  and   x20, x2, x4
P 00000054 00000AB3  add   x21, x0, x0
P 00000058 12345B37  lui   x22, 0x12345
P 0000005C 00001B97  auipc x23, 0x1
P 00000060 00108463  beq   x1, x1, +8
P 00000064 00100C13  addi  x24, x0, 1
P 00000068 00208463  beq   x1, x2, +8
P 0000006C 00209463  bne   x1, x2, +8
P 00000070 00100C13  addi  x24, x0, 1
P 00000074 00109463  bne   x1, x1, +8
P 00000078 00114463  blt   x2, x1, +8
P 0000007C 00100C13  addi  x24, x0, 1
P 00000080 0020C463  blt   x1, x2, +8
P 00000084 0020D463  bge   x1, x2, +8
P 00000088 00100C13  addi  x24, x0, 1
P 0000008C 00115463  bge   x2, x1, +8
P 00000090 0020E463  bltu  x1, x2, +8
P 00000094 00100C13  addi  x24, x0, 1
P 00000098 00116463  bltu  x2, x1, +8
P 0000009C 00117463  bgeu  x2, x1, +8
P 000000A0 00100C13  addi  x24, x0, 1
P 000000A4 0020F463  bgeu  x1, x2, +8
P 000000A8 010000EF  jal   x1, +16
P 000000AC 03300C13  addi  x24, x0, 0x33
P 000000B0 000C8067  jalr  x0, 0(x25)
P 000000B8 0C500C93  addi  x25, x0, 0xc5
P 000000BC 00008067  jalr  x0, 0(x1)
P 000000C4 004C8D67  jalr  x26, 4(x25)
P 000000C8 00002D83  lw    x27, 0(x0)
P 000000CC 00102023  sw    x1, 0(x0)
P 000000D0 000D8EB3  add   x29, x27, x0
P 000000D4 0000006F  jal   x0, 0
T alu_imm
E 00000000 1 1 00000005 0 0 0 0
E 00000004 2 1 FFFFFFFD 0 0 0 0
E 00000008 3 1 FFFFFF02 0 0 0 0
E 0000000C 4 1 000000A5 0 0 0 0
E 00000010 5 1 00000700 0 0 0 0
E 00000014 6 1 00000001 0 0 0 0
E 00000018 7 1 00000000 0 0 0 0
E 0000001C 8 1 00000050 0 0 0 0
E 00000020 9 1 0000000F 0 0 0 0
E 00000024 10 1 FFFFFFFE 0 0 0 0
E 00000028 0 0 00000000 0 0 0 0
T alu_reg
E 0000002C 11 1 00000002 0 0 0 0
E 00000030 12 1 00000008 0 0 0 0
E 00000034 13 1 000000A0 0 0 0 0
E 00000038 14 1 00000001 0 0 0 0
E 0000003C 15 1 00000000 0 0 0 0
E 00000040 16 1 FFFFFFA7 0 0 0 0
E 00000044 17 1 07FFFFFF 0 0 0 0
E 00000048 18 1 FFFFFFFF 0 0 0 0
E 0000004C 19 1 00000055 0 0 0 0
E 00000050 20 1 000000A5 0 0 0 0
E 00000054 21 1 00000000 0 0 0 0
T upper_imm
E 00000058 22 1 12345000 0 0 0 0
E 0000005C 23 1 0000105C 0 0 0 0
T branch
E 00000060 0 0 00000000 0 0 0 0
E 00000068 0 0 00000000 0 0 0 0
E 0000006C 0 0 00000000 0 0 0 0
E 00000074 0 0 00000000 0 0 0 0
E 00000078 0 0 00000000 0 0 0 0
E 00000080 0 0 00000000 0 0 0 0
E 00000084 0 0 00000000 0 0 0 0
E 0000008C 0 0 00000000 0 0 0 0
E 00000090 0 0 00000000 0 0 0 0
E 00000098 0 0 00000000 0 0 0 0
E 0000009C 0 0 00000000 0 0 0 0
E 000000A4 0 0 00000000 0 0 0 0
T jump_trace
E 000000A8 1 1 000000AC 0 1 0 0
E 000000B8 25 1 000000C5 0 0 0 0
E 000000BC 0 0 00000000 0 0 1 0
E 000000AC 24 1 00000033 0 0 0 0
E 000000B0 0 0 00000000 0 0 0 1
E 000000C4 26 1 000000C8 0 0 0 0
T illegal
E 000000C8 0 0 00000000 1 0 0 0
E 000000CC 0 0 00000000 1 0 0 0
E 000000D0 29 1 00000000 0 0 0 0
E 000000D4 0 0 00000000 0 0 0 0

/* test/tb_checker.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_checker #(
    parameter int MAX_EXP   = 64,
    parameter int MAX_TESTS = 8,
    parameter int NAME_W    = 128
) (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::commit_t commit,
    input  core_pkg::commit_t exp_list [MAX_EXP],
    input  int                exp_test [MAX_EXP],
    input  logic [NAME_W-1:0] test_name [MAX_TESTS],
    input  int                exp_count,
    output logic              done,
    output int                seen,
    output int                tests_passed,
    output int                tests_failed,
    output int                errors
);

    int test_errs;  // mismatches in the running test

    initial begin
        done         = 1'b0;
        seen         = 0;
        tests_passed = 0;
        tests_failed = 0;
        errors       = 0;
        test_errs    = 0;
    end

    task automatic check_field(input string field, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            $display("mismatch %s at entry %0d: expected %h, actual %h", field, seen, want, got);
            test_errs++;
        end
    endtask

    task automatic compare_entry(input core_pkg::commit_t want);
        check_field("pc", want.pc, commit.pc);
        check_field("inst", want.inst, commit.inst);
        check_field("we", 32'(want.we), 32'(commit.we));
        if (want.we) begin  // rd and data only mean something on a write
            check_field("rd", 32'(want.rd), 32'(commit.rd));
            check_field("w_data", want.w_data, commit.w_data);
        end
        check_field("illegal", 32'(want.illegal), 32'(commit.illegal));
        check_field("is_call", 32'(want.is_call), 32'(commit.is_call));
        check_field("is_ret", 32'(want.is_ret), 32'(commit.is_ret));
        check_field("is_tail", 32'(want.is_tail), 32'(commit.is_tail));
    endtask

    task automatic report_test(input int t);
        if (test_errs == 0) begin
            $display("test %0s: pass", test_name[t]);
            tests_passed++;
        end else begin
            $display("test %0s: fail, %0d mismatches", test_name[t], test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // commit still holds its pre-edge values here
    always @(posedge clk) begin
        if (rst && commit.valid) begin
            $display("commit marked valid while reset is asserted");
            errors++;
        end
        if (!rst && commit.valid && seen < exp_count) begin
            compare_entry(exp_list[seen]);
            if (seen + 1 == exp_count || exp_test[seen + 1] != exp_test[seen]) begin
                report_test(exp_test[seen]);  // last entry of this test
            end
            seen++;
            if (seen == exp_count) begin
                done = 1'b1;
            end
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* test/tb_top.sv */
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_top;

    localparam int    PROG_WORDS = 256;
    localparam int    MAX_EXP    = 64;
    localparam int    MAX_TESTS  = 8;
    localparam int    NAME_W     = 8 * 16;
    localparam string STIM_FILE  = "test/core_stimulus.txt";

    logic                  clk;
    logic                  rst;
    logic [31:0]           inst;
    logic [`CORE_XLEN-1:0] pc;
    core_pkg::commit_t     commit;

    logic [31:0]           prog [PROG_WORDS];
    core_pkg::commit_t     exp_list [MAX_EXP];
    int                    exp_test [MAX_EXP];
    logic [NAME_W-1:0]     test_name [MAX_TESTS];
    int                    exp_count = 0;
    int                    n_tests   = 0;
    logic                  load_ok;
    logic                  done;
    int                    seen;
    int                    tests_passed;
    int                    tests_failed;
    int                    errors;
    int                    cycles;
    int                    limit;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    rv_core_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .inst   (inst),
        .pc     (pc),
        .commit (commit)
    );

    tb_checker #(
        .MAX_EXP   (MAX_EXP),
        .MAX_TESTS (MAX_TESTS),
        .NAME_W    (NAME_W)
    ) checker_i (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .exp_list     (exp_list),
        .exp_test     (exp_test),
        .test_name    (test_name),
        .exp_count    (exp_count),
        .done         (done),
        .seen         (seen),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed),
        .errors       (errors)
    );

    function automatic logic [31:0] fetch(input logic [31:0] addr);
        if (addr[31:2] < PROG_WORDS) begin
            return prog[addr[31:2]];
        end
        return 32'h0000_0000;  // opcode 0 decodes illegal
    endfunction

    // pc moves just after each rising edge
    always @(pc) begin
        inst <= fetch(pc);
    end

    task automatic load_stimulus();
        int                    fd;
        int                    n;
        string                 line;
        logic [31:0]           addr;
        logic [31:0]           word;
        logic [31:0]           data;
        int                    rd;
        int                    we;
        int                    ill;
        int                    call;
        int                    ret;
        int                    tail;
        logic [NAME_W-1:0]     name;
        core_pkg::commit_t     entry;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {i[24:0], 7'b000_0000};  // illegal filler unique per word
        end
        load_ok = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            load_ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            case (line[0])
                "P": begin
                    n = $sscanf(line, "P %h %h", addr, word);
                    if (n == 2 && addr[31:2] < PROG_WORDS) begin
                        prog[addr[31:2]] = word;
                    end else begin
                        $display("bad program line in stimulus file: %s", line);
                        load_ok = 1'b0;
                    end
                end
                "T": begin
                    n = $sscanf(line, "T %s", name);
                    if (n_tests < MAX_TESTS) begin
                        test_name[n_tests] = name;
                        n_tests++;
                    end
                end
                "E": begin
                    n = $sscanf(line, "E %h %d %d %h %d %d %d %d",
                                addr, rd, we, data, ill, call, ret, tail);
                    if (n != 8 || exp_count >= MAX_EXP || n_tests == 0) begin
                        $display("bad expected line in stimulus file: %s", line);
                        load_ok = 1'b0;
                    end else begin
                        entry         = '0;
                        entry.valid   = 1'b1;
                        entry.pc      = addr;
                        entry.rd      = rd[4:0];
                        entry.we      = we[0];
                        entry.w_data  = data;
                        entry.illegal = ill[0];
                        entry.is_call = call[0];
                        entry.is_ret  = ret[0];
                        entry.is_tail = tail[0];
                        exp_list[exp_count] = entry;
                        exp_test[exp_count] = n_tests - 1;
                        exp_count++;
                    end
                end
                default: ;  // comments and blank lines
            endcase
        end
        $fclose(fd);
        // the reported word is the program word at the expected pc
        for (int i = 0; i < exp_count; i++) begin
            exp_list[i].inst = fetch(exp_list[i].pc);
        end
        if (exp_count == 0) begin
            load_ok = 1'b0;
        end
    endtask

    initial begin
        cycles = 0;
        load_stimulus();
        inst = fetch(pc);  // word at the pc before it first moves
        limit = 2 * exp_count + 20;
        while (load_ok && !done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!load_ok) begin
            $display("stimulus file could not be read");
        end else if (!done) begin
            $display("timeout: core stopped committing after %0d of %0d entries",
                     seen, exp_count);
        end
        $display("tests passed %0d, tests failed %0d, other errors %0d",
                 tests_passed, tests_failed, errors);
        if (load_ok && done && tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
